// File: Bender.yml
package:
  name: queue_display

sources:
  - include_dirs:
      - common
    files:
      - common/qdisp_pkg.sv
      - hdl/packet_receiver.sv
      - hdl/queue_bank.sv
      - vga/vga_timing.sv
      - vga/tile_renderer.sv
      - hdl/queue_display_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_queue_display.sv

// File: common/qdisp_defs.svh
`ifndef QDISP_DEFS_SVH
`define QDISP_DEFS_SVH

// Queue geometry
`define QD_NUM_QUEUES 4
`define QD_NUM_SLOTS 6
`define QD_SLOT_EMPTY 7

// Receiver arming
`define QD_START_CYCLES 3 // Consecutive low samples of start

// Shared drop counter
`define QD_DROP_W 11

// Timing in pixels and lines
`define QD_H_TOTAL 800
`define QD_H_SYNC 96
`define QD_V_TOTAL 525
`define QD_V_SYNC 2

// Tile grid placement
`define QD_TILE_SIZE 52
`define QD_TILE_X0 154 // Queue 0 column
`define QD_TILE_PITCH 62
`define QD_TILE_Y0 40 // Row of slot 5

`endif

// File: common/qdisp_pkg.sv
`include "qdisp_defs.svh"

package qdisp_pkg;

	typedef logic [1:0] queue_id_t;
	typedef logic [1:0] payload_t;
	typedef logic [2:0] slot_t; // Empty code or {0, payload}

	typedef struct packed {
		queue_id_t dest; // First two bits received
		payload_t value;
	} packet_t;

	typedef slot_t [`QD_NUM_SLOTS-1:0] queue_t; // Slot 0 newest
	typedef queue_t [`QD_NUM_QUEUES-1:0] queue_set_t;

	typedef logic [`QD_DROP_W-1:0] drop_cnt_t;

	typedef logic [9:0] coord_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} pixel_pos_t;

	typedef logic [7:0] rgb332_t; // RRRGGGBB

	typedef enum logic [1:0] {
		rx_idle,
		rx_wait_press,
		rx_wait_release
	} rx_state_t;

	localparam int payload_vals = 2 ** $bits(payload_t);

	// One shade per queue and value
	localparam rgb332_t tile_palette [`QD_NUM_QUEUES][payload_vals] = '{
		'{8'hE0, 8'hC0, 8'hA0, 8'h80}, // Reds
		'{8'h1C, 8'h18, 8'h14, 8'h10}, // Greens
		'{8'h03, 8'h02, 8'h01, 8'h4B}, // Blues
		'{8'hFC, 8'hD8, 8'hB4, 8'h90} // Yellows
	};

	localparam rgb332_t tile_empty = 8'h49; // Grey

endpackage

// File: filelist.f
+incdir+common
common/qdisp_pkg.sv
hdl/packet_receiver.sv
hdl/queue_bank.sv
vga/vga_timing.sv
vga/tile_renderer.sv
hdl/queue_display_top.sv
tests/tb_queue_display.sv

// File: hdl/packet_receiver.sv
`include "qdisp_defs.svh"

module packet_receiver (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic bin0,
	input logic bin1,
	output logic push,
	output qdisp_pkg::packet_t pkt
);

	import qdisp_pkg::*;

	localparam int arm_w = $clog2(`QD_START_CYCLES + 1);

	rx_state_t state;
	logic [arm_w-1:0] arm_cnt;
	logic [1:0] bit_idx;
	logic [3:0] shift_reg;
	logic one_low;
	logic rx_bit;
	logic capture;

	assign one_low = bin0 ^ bin1; // Exactly one button pressed
	assign rx_bit = ~bin0; // bin0 enters a 1
	assign capture = (state == rx_wait_press) && one_low;

	// MSB first, so the first two bits land in dest
	assign pkt = packet_t'(shift_reg);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= rx_idle;
			arm_cnt <= '0;
			bit_idx <= '0;
			push <= 1'b0;
		end else begin
			push <= 1'b0;
			case (state)
				rx_idle: begin
					if (!start) begin
						if (arm_cnt == arm_w'(`QD_START_CYCLES - 1)) begin
							state <= rx_wait_press;
							arm_cnt <= '0;
							bit_idx <= '0;
						end else begin
							arm_cnt <= arm_cnt + 1'b1;
						end
					end else begin
						arm_cnt <= '0; // Low samples must be consecutive
					end
				end
				rx_wait_press: begin
					if (one_low) begin
						bit_idx <= bit_idx + 1'b1;
						state <= rx_wait_release;
						if (bit_idx == 2'd3)
							push <= 1'b1;
					end
				end
				rx_wait_release: begin
					if (bin0 && bin1) begin
						// Index wrapped to 0 after the fourth bit
						state <= (bit_idx == 2'd0) ? rx_idle : rx_wait_press;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (capture)
			shift_reg <= {shift_reg[2:0], rx_bit};
	end

	a_push_single: assert property (@(posedge clk) disable iff (!rst_n)
		push |=> !push);

endmodule

// File: hdl/queue_bank.sv
`include "qdisp_defs.svh"

module queue_bank (
	input logic clk,
	input logic rst_n,
	input logic push,
	input qdisp_pkg::packet_t pkt,
	output qdisp_pkg::queue_set_t queues,
	output qdisp_pkg::drop_cnt_t drop_count
);

	import qdisp_pkg::*;

	localparam slot_t slot_empty = slot_t'(`QD_SLOT_EMPTY);
	localparam queue_t queue_empty = {`QD_NUM_SLOTS{slot_empty}};

	queue_t dest_q;
	queue_t shifted_q;
	slot_t new_slot;
	logic lost;

	assign dest_q = queues[pkt.dest];
	assign new_slot = {1'b0, pkt.value};
	assign shifted_q = {dest_q[`QD_NUM_SLOTS-2:0], new_slot};

	// Oldest entry falls off the end
	assign lost = dest_q[`QD_NUM_SLOTS-1] != slot_empty;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			queues <= {`QD_NUM_QUEUES{queue_empty}};
			drop_count <= '0;
		end else if (push) begin
			queues[pkt.dest] <= shifted_q;
			if (lost)
				drop_count <= drop_count + 1'b1; // Wraps freely
		end
	end

	a_drop_after_push: assert property (@(posedge clk) disable iff (!rst_n)
		$changed(drop_count) |-> $past(push));

endmodule

// File: hdl/queue_display_top.sv
module queue_display_top (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic bin0, // Low when pressed
	input logic bin1,
	output qdisp_pkg::queue_set_t queues,
	output qdisp_pkg::drop_cnt_t drop_count,
	output logic hsync,
	output logic vsync,
	output qdisp_pkg::rgb332_t color
);

	import qdisp_pkg::*;

	logic push;
	packet_t pkt;
	pixel_pos_t pos;

	packet_receiver u_rx (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.bin0(bin0),
		.bin1(bin1),
		.push(push),
		.pkt(pkt)
	);

	queue_bank u_queues (
		.clk(clk),
		.rst_n(rst_n),
		.push(push),
		.pkt(pkt),
		.queues(queues),
		.drop_count(drop_count)
	);

	vga_timing u_timing (
		.clk(clk),
		.rst_n(rst_n),
		.pos(pos),
		.hsync(hsync),
		.vsync(vsync)
	);

	tile_renderer u_render (
		.clk(clk),
		.rst_n(rst_n),
		.pos(pos),
		.queues(queues),
		.color(color)
	);

endmodule

// File: tests/tb_queue_display.sv
`include "qdisp_defs.svh"

module tb_queue_display;

	import qdisp_pkg::*;

	localparam int line_clocks = 2 * `QD_H_TOTAL; // Pixel strobe at half rate
	localparam int frame_clocks = `QD_V_TOTAL * line_clocks;
	// First vsync rise comes one frame in, then one whole frame is measured
	localparam int timeout_cycles = 2 * frame_clocks + 520000;
	// Entry q*4+v sits in byte q*4+v
	localparam logic [127:0] ref_palette = 128'h90B4D8FC_4B010203_1014181C_80A0C0E0;
	localparam rgb332_t ref_empty = 8'h49;

	logic clk;
	logic rst_n;
	logic start;
	logic bin0;
	logic bin1;
	queue_set_t queues;
	drop_cnt_t drop_count;
	logic hsync;
	logic vsync;
	rgb332_t color;

	queue_set_t ref_q;
	drop_cnt_t ref_drops;
	logic [31:0] rng_state;
	int cycles;
	int n_checks;
	int n_errors;
	int prev_errs;
	int color_checks;
	int color_errs;

	logic cmp_en;
	logic locked; // Raster position known
	logic sub; // Second clock of a pixel
	logic h_prev;
	logic v_prev;
	int tx;
	int ty;

	queue_display_top dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.bin0(bin0),
		.bin1(bin1),
		.queues(queues),
		.drop_count(drop_count),
		.hsync(hsync),
		.vsync(vsync),
		.color(color)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == timeout_cycles) begin
			$display("Run timed out after %0d cycles without finishing the tests", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state >> 16; // Upper bits have the longer period
	endfunction

	task automatic check_value(input string name, input logic [71:0] got,
			input logic [71:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("mismatch at time %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	function automatic void model_push(input queue_id_t dest, input payload_t value);
		if (ref_q[dest][`QD_NUM_SLOTS-1] != 3'(`QD_SLOT_EMPTY))
			ref_drops = ref_drops + 1'b1;
		for (int s = `QD_NUM_SLOTS - 1; s > 0; s--)
			ref_q[dest][s] = ref_q[dest][s-1];
		ref_q[dest][0] = {1'b0, value};
	endfunction

	function automatic rgb332_t ref_color(input int x, input int y, input queue_set_t qs);
		slot_t s;
		int left;
		int top;
		ref_color = 8'h00;
		for (int q = 0; q < `QD_NUM_QUEUES; q++) begin
			for (int r = 0; r < `QD_NUM_SLOTS; r++) begin
				left = `QD_TILE_X0 + q * `QD_TILE_PITCH;
				top = `QD_TILE_Y0 + r * `QD_TILE_SIZE;
				if (x >= left && x < left + `QD_TILE_SIZE &&
						y >= top && y < top + `QD_TILE_SIZE) begin
					s = qs[q][`QD_NUM_SLOTS - 1 - r]; // Oldest slot on top
					if (s == 3'(`QD_SLOT_EMPTY))
						ref_color = ref_empty;
					else
						ref_color = ref_palette[8 * (q * 4 + s[1:0]) +: 8];
				end
			end
		end
	endfunction

	function automatic bit on_sample_grid(input int x, input int y);
		int cx;
		int cy;
		cx = x - `QD_TILE_X0 - `QD_TILE_SIZE / 2;
		cy = y - `QD_TILE_Y0 - `QD_TILE_SIZE / 2;
		if (cx >= 0 && cx % `QD_TILE_PITCH == 0 && cx < `QD_NUM_QUEUES * `QD_TILE_PITCH &&
				cy >= 0 && cy % `QD_TILE_SIZE == 0 && cy < `QD_NUM_SLOTS * `QD_TILE_SIZE)
			return 1'b1; // Tile centre
		return (x % 7 == 3) && (y % 7 == 3); // Gaps, edges and border
	endfunction

	// Compare colour and then track the raster from the sync outputs
	always @(negedge clk) begin
		if (cmp_en && locked && on_sample_grid(tx, ty)) begin
			color_checks++;
			prev_errs = n_errors;
			check_value($sformatf("color at %0d,%0d", tx, ty), color, ref_color(tx, ty, ref_q));
			color_errs += n_errors - prev_errs;
		end
		if (hsync && !h_prev) begin
			if (vsync && !v_prev) begin
				ty = 0;
				locked = 1'b1;
			end else begin
				ty = ty + 1;
			end
			tx = 0;
			sub = 1'b0;
		end else begin
			if (sub)
				tx = tx + 1;
			sub = !sub;
		end
		h_prev = hsync;
		v_prev = vsync;
	end

	task automatic hold_start(input int n);
		start <= 1'b0;
		repeat (n) @(posedge clk);
		start <= 1'b1;
	endtask

	task automatic press_bit(input logic value, input int hold);
		if (value)
			bin0 <= 1'b0; // bin0 enters a 1
		else
			bin1 <= 1'b0;
		repeat (hold) @(posedge clk);
		bin0 <= 1'b1;
		bin1 <= 1'b1;
		repeat (3) @(posedge clk);
	endtask

	task automatic press_bits(input logic [3:0] bits);
		for (int i = 3; i >= 0; i--)
			press_bit(bits[i], 3 + lcg_next() % 4);
	endtask

	task automatic press_both(input int hold);
		bin0 <= 1'b0;
		bin1 <= 1'b0;
		repeat (hold) @(posedge clk);
		bin0 <= 1'b1;
		bin1 <= 1'b1;
		repeat (3) @(posedge clk);
	endtask

	task automatic send_packet(input queue_id_t dest, input payload_t value);
		@(posedge clk);
		hold_start(`QD_START_CYCLES);
		press_bits({dest, value});
		model_push(dest, value);
	endtask

	task automatic settle_and_compare();
		repeat (10) @(posedge clk);
		@(negedge clk);
		check_value("queues", queues, ref_q);
		check_value("drop_count", drop_count, ref_drops);
	endtask

	task automatic wait_sync_edge(input bit use_v, input logic level, output int stamp);
		logic prev;
		logic cur;
		@(negedge clk);
		cur = use_v ? vsync : hsync;
		prev = cur;
		while (!(cur == level && prev != level)) begin
			prev = cur;
			@(negedge clk);
			cur = use_v ? vsync : hsync;
		end
		stamp = cycles;
	endtask

	task automatic report_test(input int num, input string name, input int errs);
		$display("Test %0d (%s) finished with %0d errors", num, name, errs);
	endtask

	initial begin
		int t0;
		int t1;
		int t2;
		int t3;
		int t4;
		int t5;
		int e_start;
		payload_t sent [8];
		rst_n = 1'b0;
		start = 1'b1;
		bin0 = 1'b1;
		bin1 = 1'b1;
		rng_state = 32'hf90f4bc7;
		cycles = 0;
		n_checks = 0;
		n_errors = 0;
		color_checks = 0;
		color_errs = 0;
		cmp_en = 1'b0;
		locked = 1'b0;
		sub = 1'b0;
		h_prev = 1'b1;
		v_prev = 1'b1;
		tx = 0;
		ty = 0;
		ref_q = {(`QD_NUM_QUEUES * `QD_NUM_SLOTS){3'(`QD_SLOT_EMPTY)}};
		ref_drops = '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		e_start = n_errors;
		for (int q = 0; q < `QD_NUM_QUEUES; q++) begin
			send_packet(queue_id_t'(q), payload_t'((q + 1) % 4));
			settle_and_compare();
		end
		report_test(1, "packet decode", n_errors - e_start);

		e_start = n_errors;
		for (int i = 0; i < 8; i++) begin
			sent[i] = payload_t'(lcg_next() % 4);
			send_packet(2'd2, sent[i]);
		end
		settle_and_compare();
		for (int s = 0; s < `QD_NUM_SLOTS; s++)
			check_value($sformatf("queue 2 slot %0d", s), queues[2][s], {1'b0, sent[7 - s]});
		report_test(2, "overflow and drops", n_errors - e_start);

		e_start = n_errors;
		@(posedge clk);
		press_bits(4'b1010); // Receiver idle
		settle_and_compare();
		@(posedge clk);
		hold_start(`QD_START_CYCLES - 1);
		press_bits(4'b0110);
		settle_and_compare();
		@(posedge clk);
		hold_start(`QD_START_CYCLES);
		press_both(4);
		press_both(5);
		settle_and_compare();
		send_packet(2'd1, 2'd3);
		settle_and_compare();
		report_test(3, "ignored input", n_errors - e_start);

		e_start = n_errors;
		@(posedge clk);
		cmp_en = 1'b1;
		wait_sync_edge(1'b0, 1'b1, t0);
		wait_sync_edge(1'b0, 1'b0, t1);
		wait_sync_edge(1'b0, 1'b1, t2);
		check_value("line period", t2 - t0, line_clocks);
		check_value("hsync high time", t1 - t0, 2 * `QD_H_SYNC);
		wait_sync_edge(1'b1, 1'b1, t3);
		wait_sync_edge(1'b1, 1'b0, t4);
		wait_sync_edge(1'b1, 1'b1, t5);
		check_value("vsync high time", t4 - t3, `QD_V_SYNC * line_clocks);
		check_value("frame period", t5 - t3, frame_clocks);
		@(posedge clk);
		cmp_en = 1'b0;
		report_test(4, "sync timing", n_errors - e_start - color_errs);

		if (color_checks == 0) begin
			$display("Tile colour test compared no pixels, raster never locked to the sync outputs");
			n_errors++;
			color_errs++;
		end
		report_test(5, "tile colours", color_errs);

		$display("Tests: 5, checks: %0d, colour samples: %0d, errors: %0d",
			n_checks, color_checks, n_errors);
		if (n_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: vga/tile_renderer.sv
`include "qdisp_defs.svh"

module tile_renderer (
	input logic clk,
	input logic rst_n,
	input qdisp_pkg::pixel_pos_t pos,
	input qdisp_pkg::queue_set_t queues,
	output qdisp_pkg::rgb332_t color
);

	import qdisp_pkg::*;

	localparam int slot_idx_w = $clog2(`QD_NUM_SLOTS);

	logic col_hit;
	queue_id_t col;
	logic row_hit;
	logic [slot_idx_w-1:0] slot_idx;
	slot_t cur_slot;
	rgb332_t next_color;

	// Column lookup
	always_comb begin
		col_hit = 1'b0;
		col = '0;
		for (int q = 0; q < `QD_NUM_QUEUES; q++) begin
			if (pos.x >= `QD_TILE_X0 + q * `QD_TILE_PITCH &&
					pos.x < `QD_TILE_X0 + q * `QD_TILE_PITCH + `QD_TILE_SIZE) begin
				col_hit = 1'b1;
				col = queue_id_t'(q);
			end
		end
	end

	// Row lookup with the oldest slot on top
	always_comb begin
		row_hit = 1'b0;
		slot_idx = '0;
		for (int r = 0; r < `QD_NUM_SLOTS; r++) begin
			if (pos.y >= `QD_TILE_Y0 + r * `QD_TILE_SIZE &&
					pos.y < `QD_TILE_Y0 + (r + 1) * `QD_TILE_SIZE) begin
				row_hit = 1'b1;
				slot_idx = slot_idx_w'(`QD_NUM_SLOTS - 1 - r);
			end
		end
	end

	assign cur_slot = queues[col][slot_idx];

	always_comb begin
		if (!(col_hit && row_hit))
			next_color = '0; // Background
		else if (cur_slot == slot_t'(`QD_SLOT_EMPTY))
			next_color = tile_empty;
		else
			next_color = tile_palette[col][cur_slot[$bits(payload_t)-1:0]];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			color <= '0;
		else
			color <= next_color;
	end

endmodule

// File: vga/vga_timing.sv
`include "qdisp_defs.svh"

module vga_timing (
	input logic clk,
	input logic rst_n,
	output qdisp_pkg::pixel_pos_t pos,
	output logic hsync,
	output logic vsync
);

	import qdisp_pkg::*;

	logic pix_en;
	coord_t x_cnt;
	coord_t y_cnt;
	logic line_end;

	assign line_end = x_cnt == coord_t'(`QD_H_TOTAL - 1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pix_en <= 1'b1;
			x_cnt <= '0;
			y_cnt <= '0;
		end else begin
			pix_en <= ~pix_en; // Half-rate pixel strobe
			if (pix_en) begin
				if (line_end) begin
					x_cnt <= '0;
					if (y_cnt == coord_t'(`QD_V_TOTAL - 1))
						y_cnt <= '0;
					else
						y_cnt <= y_cnt + 1'b1;
				end else begin
					x_cnt <= x_cnt + 1'b1;
				end
			end
		end
	end

	assign pos = '{x: x_cnt, y: y_cnt};

	// Sync pulses sit at the start of line and frame
	assign hsync = x_cnt < coord_t'(`QD_H_SYNC);
	assign vsync = y_cnt < coord_t'(`QD_V_SYNC);

	a_x_range: assert property (@(posedge clk) disable iff (!rst_n)
		x_cnt < coord_t'(`QD_H_TOTAL));

endmodule
